// File: stage_config.svh
// Widths for the RV32I execute path; PC_WIDTH must not exceed DATA_WIDTH and ALUOP_WIDTH must fit every AluOp code
`ifndef STAGE_CONFIG_SVH
`define STAGE_CONFIG_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

`define DATA_WIDTH  32                                  // Operand and result word

`define PC_WIDTH    32                                  // Instruction address, zero-extended into A

// ----------------------------------------
// Control encodings
// ----------------------------------------

`define ALUOP_WIDTH 4                                   // Room for 16 codes, 11 in use

`endif

// File: types.sv
// Shared execute types; field order inside the structs sets the packed layout seen by the testbench
`include "stage_config.svh"

package types;

    // ----------------------------------------
    // ALU operation codes
    // ----------------------------------------

    typedef enum logic [`ALUOP_WIDTH-1:0] {
        ADD   = `ALUOP_WIDTH'(0),                       // A + B
        SUB   = `ALUOP_WIDTH'(1),                       // A - B
        SLL   = `ALUOP_WIDTH'(2),                       // Logical shift left
        SLT   = `ALUOP_WIDTH'(3),                       // Signed less than
        SLTU  = `ALUOP_WIDTH'(4),                       // Unsigned less than
        XOR   = `ALUOP_WIDTH'(5),
        SRL   = `ALUOP_WIDTH'(6),                       // Logical shift right
        SRA   = `ALUOP_WIDTH'(7),                       // Arithmetic shift right
        OR    = `ALUOP_WIDTH'(8),
        AND   = `ALUOP_WIDTH'(9),
        PASSB = `ALUOP_WIDTH'(10)                       // B straight through, used by LUI
    } AluOp;

    // ----------------------------------------
    // Decode to execute request
    // ----------------------------------------

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] InstIMM;                // Immediate of the instruction
        logic [`DATA_WIDTH-1:0] DataA;                  // RS1 value
        logic [`DATA_WIDTH-1:0] DataB;                  // RS2 value
        logic [`PC_WIDTH-1:0]   PC;                     // Address of the instruction
        logic                   OperandASel;            // 1 selects PC for operand A
        logic                   OperandBSel;            // 1 selects IMM for operand B
        AluOp                   AluControl;             // Operation for the ALU
    } ExecReq;

    // ----------------------------------------
    // Execute to memory response
    // ----------------------------------------

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] Result;                 // ALU output
        logic [`DATA_WIDTH-1:0] DataB;                  // Store data
    } ExecRsp;

endpackage

// File: Alu.sv
// Combinational RV32I integer ALU; no multiply or divide, unused opcodes return zero
`timescale 1ns/10ps
`include "stage_config.svh"

module Alu
    import types::*;
(
    input  AluOp                   i_Op,                // Operation select
    input  logic [`DATA_WIDTH-1:0] i_OperandA,          // First operand
    input  logic [`DATA_WIDTH-1:0] i_OperandB,          // Second operand
    output logic [`DATA_WIDTH-1:0] o_Result             // Operation result
);

    localparam int SHAMT_WIDTH = $clog2(`DATA_WIDTH);   // 5 bits for a 32-bit word

    logic [SHAMT_WIDTH-1:0] shamt;                      // Shift amount
    logic                   ltSigned;                   // Signed compare
    logic                   ltUnsigned;                 // Unsigned compare

    // ----------------------------------------
    // Shared terms
    // ----------------------------------------

    assign shamt      = i_OperandB[SHAMT_WIDTH-1:0];   // Upper bits of B ignored
    assign ltSigned   = $signed(i_OperandA) < $signed(i_OperandB);
    assign ltUnsigned = i_OperandA < i_OperandB;

    // ----------------------------------------
    // Operation select
    // ----------------------------------------

    always_comb begin
        case (i_Op)
            ADD:
                o_Result = i_OperandA + i_OperandB;     // Wraps at word width
            SUB:
                o_Result = i_OperandA - i_OperandB;
            SLL:
                o_Result = i_OperandA << shamt;
            SLT:
                o_Result = `DATA_WIDTH'(ltSigned);      // 1 or 0
            SLTU:
                o_Result = `DATA_WIDTH'(ltUnsigned);    // 1 or 0
            XOR:
                o_Result = i_OperandA ^ i_OperandB;
            SRL:
                o_Result = i_OperandA >> shamt;         // Zero fill
            SRA:
                o_Result = $unsigned($signed(i_OperandA) >>> shamt); // Sign fill
            OR:
                o_Result = i_OperandA | i_OperandB;
            AND:
                o_Result = i_OperandA & i_OperandB;
            PASSB:
                o_Result = i_OperandB;                  // LUI value comes in as IMM
            default:
                o_Result = '0;                          // Unknown code
        endcase
    end

endmodule

// File: StageEX.sv
// Purely combinational execute stage; the PC is zero-extended when narrower than the data word
`timescale 1ns/10ps
`include "stage_config.svh"

module StageEX
    import types::*;
(
    input  ExecReq i_Req,                               // Decoded instruction
    output ExecRsp o_Rsp                                // Result and store data
);

    logic [`DATA_WIDTH-1:0] operandA;                   // ALU input A
    logic [`DATA_WIDTH-1:0] operandB;                   // ALU input B
    logic [`DATA_WIDTH-1:0] aluResult;                  // ALU output

    // ----------------------------------------
    // Operand A select, RS1 or PC
    // ----------------------------------------

    assign operandA = i_Req.OperandASel ?
                      `DATA_WIDTH'(i_Req.PC) :          // AUIPC, JAL style
                      i_Req.DataA;

    // ----------------------------------------
    // Operand B select, RS2 or IMM
    // ----------------------------------------

    assign operandB = i_Req.OperandBSel ?
                      i_Req.InstIMM :                   // I and U type
                      i_Req.DataB;

    // ----------------------------------------
    // ALU
    // ----------------------------------------

    Alu Alu (
        .i_Op       (i_Req.AluControl),
        .i_OperandA (operandA),
        .i_OperandB (operandB),
        .o_Result   (aluResult)
    );

    // Store data bypasses the operand B mux
    assign o_Rsp.Result = aluResult;
    assign o_Rsp.DataB  = i_Req.DataB;                  // Unchanged RS2

endmodule

// File: PipeReg.sv
// One-entry valid/ready register; one cycle latency, full throughput, ready depends on i_Ready
`timescale 1ns/10ps

module PipeReg #(
    parameter type T = logic                            // Payload type
) (
    input  logic i_Clock,                               // Rising edge clock
    input  logic i_rstN,                                // Sync reset, active low
    // Upstream side
    input  logic i_Valid,                               // Beat offered
    output logic o_Ready,                               // Beat can be taken
    input  T     i_Data,                                // Offered payload
    // Downstream side
    output logic o_Valid,                               // Beat held
    input  logic i_Ready,                               // Downstream takes it
    output T     o_Data                                 // Held payload
);

    logic validQ;                                       // Register holds a beat
    T     dataQ;                                        // Held payload
    logic load;                                         // Upstream transfer

    // ----------------------------------------
    // Handshake
    // ----------------------------------------

    assign o_Ready = !validQ || i_Ready;                // Empty or draining this cycle
    assign load    = i_Valid && o_Ready;

    // ----------------------------------------
    // Valid flag
    // ----------------------------------------

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            validQ <= 1'b0;                             // Empty after reset
        end else if (o_Ready) begin
            validQ <= i_Valid;                          // Refill or go empty
        end
    end

    // ----------------------------------------
    // Payload
    // ----------------------------------------

    always_ff @(posedge i_Clock) begin
        if (load) begin
            dataQ <= i_Data;                            // Held while stalled
        end
    end

    assign o_Valid = validQ;
    assign o_Data  = dataQ;

endmodule

// File: ExecUnit.sv
// Execute unit top; two cycles request to response, no forwarding, hazard or flush handling
`timescale 1ns/10ps

module ExecUnit
    import types::*;
(
    input  logic   i_Clock,                             // Rising edge clock
    input  logic   i_rstN,                              // Sync reset, active low
    // Request channel from decode
    input  logic   i_ReqValid,                          // Request offered
    output logic   o_ReqReady,                          // Request accepted
    input  ExecReq i_Req,                               // Decoded instruction
    // Response channel to memory
    output logic   o_RspValid,                          // Response offered
    input  logic   i_RspReady,                          // Response taken
    output ExecRsp o_Rsp                                // Result and store data
);

    logic   idExValid;                                  // ID/EX holds an instruction
    ExecReq idExReq;                                    // Instruction in execute
    logic   exMemReady;                                 // EX/MEM can take a result
    ExecRsp stageRsp;                                   // Combinational result

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------

    PipeReg #(
        .T (ExecReq)
    ) IdExReg (
        .i_Clock (i_Clock),
        .i_rstN  (i_rstN),
        .i_Valid (i_ReqValid),
        .o_Ready (o_ReqReady),                          // Low only when both stages stall
        .i_Data  (i_Req),
        .o_Valid (idExValid),
        .i_Ready (exMemReady),
        .o_Data  (idExReq)
    );

    // ----------------------------------------
    // Execute
    // ----------------------------------------

    StageEX Execute (
        .i_Req (idExReq),
        .o_Rsp (stageRsp)
    );

    // ----------------------------------------
    // EX/MEM register
    // ----------------------------------------

    PipeReg #(
        .T (ExecRsp)
    ) ExMemReg (
        .i_Clock (i_Clock),
        .i_rstN  (i_rstN),
        .i_Valid (idExValid),                           // Valid follows the instruction
        .o_Ready (exMemReady),
        .i_Data  (stageRsp),
        .o_Valid (o_RspValid),
        .i_Ready (i_RspReady),
        .o_Data  (o_Rsp)
    );

endmodule

// File: tb_ExecUnit.sv
// Testbench for ExecUnit; reads 9 hex words per vector from exec_golden.txt in the run directory
`timescale 1ns/10ps
`include "stage_config.svh"

module tb_ExecUnit
    import types::*;
();

    localparam int CLK_PERIOD   = 100;                  // ns
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY  = 1;                    // Inputs change after the edge
    localparam int VEC_WORDS    = 9;                    // Words per golden vector
    localparam int MAX_VECTORS  = 256;

    logic   i_Clock = 1'b0;
    logic   i_rstN;
    logic   i_ReqValid;
    logic   o_ReqReady;
    ExecReq i_Req;
    logic   o_RspValid;
    logic   i_RspReady;
    ExecRsp o_Rsp;

    logic [31:0] goldenMem [0:MAX_VECTORS*VEC_WORDS-1]; // Flat vector storage
    int          acceptEdge [0:MAX_VECTORS-1];          // Edge that took each request
    int          numVectors    = 0;
    int          acceptedCount = 0;                     // Requests taken by the DUT
    int          respCount     = 0;                     // Responses taken from the DUT
    int          cycleCount    = 0;                     // Rising edges so far
    int          latencyTwo    = 0;                     // Responses with minimum latency
    int          mismatchCount = 0;
    int          otherErrors   = 0;
    integer      seed          = 61;
    logic        vectorsLoaded = 1'b0;
    logic        resetChecked  = 1'b0;

    ExecUnit i_ExecUnit (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_ReqValid (i_ReqValid),
        .o_ReqReady (o_ReqReady),
        .i_Req      (i_Req),
        .o_RspValid (o_RspValid),
        .i_RspReady (i_RspReady),
        .o_Rsp      (o_Rsp)
    );

    always #(CLK_PERIOD/2) i_Clock = ~i_Clock;          // 100 ns period

    always @(posedge i_Clock) begin
        cycleCount <= cycleCount + 1;
    end

    // ----------------------------------------
    // Vector handling
    // ----------------------------------------

    task automatic loadVectors();
        $readmemh("exec_golden.txt", goldenMem);
        while (numVectors < MAX_VECTORS && !$isunknown(goldenMem[numVectors*VEC_WORDS])) begin
            numVectors++;                               // Unread entries stay X
        end
        assert (numVectors > 0) else begin
            $display("ERROR: no vectors could be read from exec_golden.txt");
            otherErrors++;
        end
        vectorsLoaded = 1'b1;
    endtask

    function automatic ExecReq buildRequest(input int idx);
        ExecReq req;
        int     base;
        base            = idx * VEC_WORDS;
        req.AluControl  = AluOp'(goldenMem[base][`ALUOP_WIDTH-1:0]);
        req.OperandASel = goldenMem[base+1][0];
        req.OperandBSel = goldenMem[base+2][0];
        req.DataA       = goldenMem[base+3][`DATA_WIDTH-1:0];
        req.DataB       = goldenMem[base+4][`DATA_WIDTH-1:0];
        req.InstIMM     = goldenMem[base+5][`DATA_WIDTH-1:0];
        req.PC          = goldenMem[base+6][`PC_WIDTH-1:0];
        return req;
    endfunction

    // Holds the request until ready is seen at a falling edge
    task automatic sendRequest(input int idx);
        @(posedge i_Clock);
        #DRIVE_DELAY;
        i_ReqValid = 1'b1;
        i_Req      = buildRequest(idx);
        @(negedge i_Clock);
        while (o_ReqReady !== 1'b1) begin
            @(negedge i_Clock);                         // Stalled with the payload held
        end
    endtask

    task automatic printCounts();
        $display("Summary: %0d mismatches, %0d other errors, %0d of %0d responses",
                 mismatchCount, otherErrors, respCount, numVectors);
    endtask

    // ----------------------------------------
    // Response back-pressure
    // ----------------------------------------

    initial begin : rspReadyDriver
        integer randBits;
        @(posedge i_rstN);                              // First cycle out of reset keeps it low
        @(posedge i_Clock);
        #DRIVE_DELAY;
        i_RspReady = 1'b1;
        repeat (8) @(posedge i_Clock);                  // Early responses see ready high
        forever begin
            @(posedge i_Clock);
            #DRIVE_DELAY;
            randBits   = $random(seed);
            i_RspReady = randBits[0];
        end
    end

    // ----------------------------------------
    // Monitor sampled at the falling edge
    // ----------------------------------------

    always @(negedge i_Clock) begin : responseMonitor
        int base;
        int latency;
        if (cycleCount >= 1 && (!i_rstN || !resetChecked)) begin
            assert (o_RspValid === 1'b0 && o_ReqReady === 1'b1) else begin
                $display("ERROR at %0t: wrong reset state, o_RspValid=%b o_ReqReady=%b",
                         $time, o_RspValid, o_ReqReady);
                otherErrors++;
            end
            resetChecked = i_rstN;                      // First cycle after release too
        end
        if (i_rstN) begin
            // Ready may only drop with both registers full and stalled
            assert (o_ReqReady === 1'b1 || (acceptedCount - respCount == 2 && !i_RspReady))
            else begin
                $display("ERROR at %0t: o_ReqReady low while the pipe can still accept", $time);
                otherErrors++;
            end
            if (o_RspValid === 1'b1 && i_RspReady === 1'b1) begin
                assert (respCount < acceptedCount && respCount < numVectors) else begin
                    $display("ERROR at %0t: response with no pending request", $time);
                    otherErrors++;
                end
                if (respCount < acceptedCount && respCount < numVectors) begin
                    base    = respCount * VEC_WORDS;
                    latency = cycleCount + 1 - acceptEdge[respCount];
                    assert (o_Rsp.Result === goldenMem[base+7]) else begin
                        $display("MISMATCH at %0t: vector %0d Result expected %h got %h",
                                 $time, respCount, goldenMem[base+7], o_Rsp.Result);
                        mismatchCount++;
                    end
                    assert (o_Rsp.DataB === goldenMem[base+8]) else begin
                        $display("MISMATCH at %0t: vector %0d DataB expected %h got %h",
                                 $time, respCount, goldenMem[base+8], o_Rsp.DataB);
                        mismatchCount++;
                    end
                    assert (latency >= 2) else begin
                        $display("MISMATCH at %0t: vector %0d latency expected 2 or more got %0d",
                                 $time, respCount, latency);
                        mismatchCount++;
                    end
                    if (latency == 2) begin
                        latencyTwo++;
                    end
                end
                respCount++;                            // Transfer at the next rising edge
            end
            if (i_ReqValid === 1'b1 && o_ReqReady === 1'b1) begin
                acceptEdge[acceptedCount] = cycleCount + 1;
                acceptedCount++;
            end
        end
    end

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------

    initial begin : watchdog
        wait (vectorsLoaded);
        #((numVectors * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("ERROR at %0t: watchdog expired with %0d of %0d responses missing",
                 $time, numVectors - respCount, numVectors);
        otherErrors++;
        printCounts();
        $display("TEST FAILED");
        $finish;
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin : mainFlow
        int idx;
        i_rstN     = 1'b0;
        i_ReqValid = 1'b0;
        i_Req      = '0;
        i_RspReady = 1'b0;                              // Ready out then shows the ID/EX flag
        loadVectors();
        repeat (RESET_CYCLES) @(posedge i_Clock);
        #DRIVE_DELAY;
        i_rstN = 1'b1;
        for (idx = 0; idx < numVectors; idx++) begin
            if (idx % 5 == 4) begin                     // One idle cycle now and then
                @(posedge i_Clock);
                #DRIVE_DELAY;
                i_ReqValid = 1'b0;
                i_Req      = '0;
            end
            sendRequest(idx);
        end
        @(posedge i_Clock);
        #DRIVE_DELAY;
        i_ReqValid = 1'b0;
        wait (respCount >= numVectors);
        repeat (4) @(posedge i_Clock);                  // Catch late duplicates
        assert (respCount == numVectors) else begin
            $display("ERROR: %0d responses seen for %0d requests", respCount, numVectors);
            otherErrors++;
        end
        assert (latencyTwo > 0) else begin
            $display("ERROR: no response completed two cycles after its request");
            otherErrors++;
        end
        printCounts();
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: exec_golden.txt
// op asel bsel DataA DataB IMM PC Result DataB, hex; op ADD 0 SUB 1 SLL 2 SLT 3 SLTU 4
// XOR 5 SRL 6 SRA 7 OR 8 AND 9 PASSB A
0 0 0 00000005 00000003 00000000 00000000 00000008 00000003
0 0 0 FFFFFFFF 00000001 00000000 00000000 00000000 00000001
0 0 0 7FFFFFFF 00000001 00000000 00000000 80000000 00000001
0 0 0 12345678 87654321 00000000 00000000 99999999 87654321
1 0 0 0000000A 00000003 00000000 00000000 00000007 00000003
1 0 0 00000000 00000001 00000000 00000000 FFFFFFFF 00000001
1 0 0 80000000 00000001 00000000 00000000 7FFFFFFF 00000001
5 0 0 F0F0F0F0 0FF00FF0 00000000 00000000 FF00FF00 0FF00FF0
5 0 0 AAAAAAAA FFFFFFFF 00000000 00000000 55555555 FFFFFFFF
8 0 0 F0F0F0F0 0FF00FF0 00000000 00000000 FFF0FFF0 0FF00FF0
8 0 0 00000000 00000000 00000000 00000000 00000000 00000000
9 0 0 F0F0F0F0 0FF00FF0 00000000 00000000 00F000F0 0FF00FF0
9 0 0 DEADBEEF 0000FFFF 00000000 00000000 0000BEEF 0000FFFF
3 0 0 FFFFFFFF 00000001 00000000 00000000 00000001 00000001
4 0 0 FFFFFFFF 00000001 00000000 00000000 00000000 00000001
3 0 0 00000001 FFFFFFFF 00000000 00000000 00000000 FFFFFFFF
4 0 0 00000001 FFFFFFFF 00000000 00000000 00000001 FFFFFFFF
3 0 0 80000000 7FFFFFFF 00000000 00000000 00000001 7FFFFFFF
4 0 0 80000000 7FFFFFFF 00000000 00000000 00000000 7FFFFFFF
3 0 0 00000005 00000005 00000000 00000000 00000000 00000005
2 0 0 00000001 0000001F 00000000 00000000 80000000 0000001F
2 0 0 00000001 00000021 00000000 00000000 00000002 00000021
2 0 0 12345678 00000004 00000000 00000000 23456780 00000004
6 0 0 80000000 0000001F 00000000 00000000 00000001 0000001F
6 0 0 F0000000 00000024 00000000 00000000 0F000000 00000024
7 0 0 80000000 0000001F 00000000 00000000 FFFFFFFF 0000001F
7 0 0 F0000000 00000004 00000000 00000000 FF000000 00000004
7 0 0 70000000 00000004 00000000 00000000 07000000 00000004
7 0 0 80000000 00000020 00000000 00000000 80000000 00000020
0 1 1 DEADBEEF CAFEF00D 00001000 00000400 00001400 CAFEF00D
0 1 1 00000000 11111111 FFFFF000 00002004 00001004 11111111
0 0 1 00000010 22222222 FFFFFFFF 00000000 0000000F 22222222
0 0 1 7FFFFFFF 33333333 00000001 00000000 80000000 33333333
5 0 1 0000FFFF 44444444 FFFFFFFF 00000000 FFFF0000 44444444
9 0 1 12345678 55555555 000000FF 00000000 00000078 55555555
3 0 1 FFFFFFFE 00000000 FFFFFFFF 00000000 00000001 00000000
4 0 1 00000000 66666666 00000001 00000000 00000001 66666666
2 0 1 00000003 7777777F 00000002 00000000 0000000C 7777777F
7 0 1 80000010 00000000 00000004 00000000 F8000001 00000000
A 0 1 DEADBEEF 88888888 ABCDE000 00000100 ABCDE000 88888888
A 0 0 11111111 99999999 00000000 00000000 99999999 99999999
A 1 1 00000000 01234567 12345000 00000FFC 12345000 01234567
1 1 0 FFFFFFFF 00000004 00000000 00001000 00000FFC 00000004
8 1 1 00000000 00000000 00000003 00000100 00000103 00000000

// File: project.f
+incdir+.
types.sv
Alu.sv
StageEX.sv
PipeReg.sv
ExecUnit.sv
tb_ExecUnit.sv
